//--- qm_checker.sv
// Concurrent assertions on the queue state store, bound into qm_queue_states
`timescale 1ns/1ps

module qm_checker (
    input logic                                enqueue_queue_occupancy_a4l,
    input logic                                rst,
    input logic                                tail_rd_req,
    input logic                                tail_wr_en,
    input logic [qm_queue_pkg::QUEUE_W-1:0]    tail_queue,
    input logic                                head_req,
    input logic [qm_queue_pkg::QUEUE_W-1:0]    head_queue,
    input logic [qm_queue_pkg::NUM_QUEUES-1:0] queue_empty,
    input logic [qm_queue_pkg::WCNT_W-1:0]     wcnt_0,
    input logic [qm_queue_pkg::WCNT_W-1:0]     wcnt_1,
    input logic [qm_queue_pkg::WCNT_W-1:0]     wcnt_2,
    input logic [qm_queue_pkg::WCNT_W-1:0]     wcnt_3
);

    // Write-back follows its lookup by one cycle on the same queue
    tail_write_after_read: assert property (
        @(posedge enqueue_queue_occupancy_a4l) disable iff (rst)
        tail_wr_en |-> $past(tail_rd_req) && (tail_queue == $past(tail_queue))
    ) else $error("tail write without a lookup of that queue one cycle earlier");

    head_not_empty: assert property (
        @(posedge enqueue_queue_occupancy_a4l) disable iff (rst)
        head_req |-> !queue_empty[head_queue]
    ) else $error("head request on an empty queue");

    // Sum of all queues fits in the buffer
    words_in_capacity: assert property (
        @(posedge enqueue_queue_occupancy_a4l) disable iff (rst)
        (wcnt_0 + wcnt_1 + wcnt_2 + wcnt_3) <=
            qm_geometry_pkg::NUM_PAGES * qm_geometry_pkg::WORDS_PER_PAGE
    ) else $error("word counts exceed buffer capacity");

endmodule

bind qm_queue_states qm_checker u_checker (
    .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
    .rst         (rst),
    .tail_rd_req (tail.rd_req),
    .tail_wr_en  (tail.wr_en),
    .tail_queue  (tail.queue),
    .head_req    (head.req),
    .head_queue  (head.queue),
    .queue_empty (queue_empty),
    .wcnt_0      (wcnt[0]),
    .wcnt_1      (wcnt[1]),
    .wcnt_2      (wcnt[2]),
    .wcnt_3      (wcnt[3])
);

//--- qm_dequeue.sv
// Dequeue engine, head lookup to buffer word address and page release
`timescale 1ns/1ps

module qm_dequeue (
    input  logic                                enqueue_queue_occupancy_a4l,
    input  logic                                rst,
    input  logic                                deq_valid,
    input  logic [qm_queue_pkg::QUEUE_W-1:0]    deq_queue,
    input  logic [qm_geometry_pkg::BYTES_W-1:0] deq_bytes,
    output logic                                deq_ready,
    input  logic [qm_queue_pkg::NUM_QUEUES-1:0] queue_empty,
    output logic                                rd_valid,
    output logic [qm_geometry_pkg::ADDR_W-1:0]  rd_addr,
    output logic                                release_valid,
    output logic [qm_geometry_pkg::PAGE_W-1:0]  release_page,
    head_port_if.consumer                       head
);

    logic                                busy;
    logic                                accept;
    logic [qm_queue_pkg::QUEUE_W-1:0]    q_hold;
    logic [qm_geometry_pkg::BYTES_W-1:0] bytes_hold;

    assign deq_ready = !busy;
    assign accept    = deq_valid && !busy;

    // Empty queues take the request but never reach the store
    assign head.req       = accept && !queue_empty[deq_queue];
    assign head.queue     = busy ? q_hold : deq_queue;
    assign head.sub_bytes = bytes_hold;

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= accept;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (accept) begin
            q_hold     <= deq_queue;
            bytes_hold <= deq_bytes;
        end
    end

    // Word address is page times words per page plus offset
    assign rd_valid = head.rd_valid;
    assign rd_addr  = {head.page_ptr, head.head_ptr};

    // Page goes back to the free list once its last word is read
    assign release_valid = head.rd_valid &&
                           (head.head_ptr == qm_geometry_pkg::WORDS_PER_PAGE - 1);
    assign release_page  = head.page_ptr;

endmodule

//--- qm_enqueue.sv
// Enqueue engine with the free page list and the two-cycle tail update sequencer
`timescale 1ns/1ps

module qm_enqueue (
    input  logic                                enqueue_queue_occupancy_a4l,
    input  logic                                rst,
    input  logic                                enq_valid,
    input  logic [qm_queue_pkg::QUEUE_W-1:0]    enq_queue,
    input  logic [qm_geometry_pkg::BYTES_W-1:0] enq_bytes,
    output logic                                enq_ready,
    output logic                                enq_drop,
    input  logic                                release_valid,
    input  logic [qm_geometry_pkg::PAGE_W-1:0]  release_page,
    tail_port_if.producer                       tail
);

    logic [qm_geometry_pkg::PAGE_W-1:0]     free_list [qm_geometry_pkg::NUM_PAGES];
    logic [qm_geometry_pkg::PAGE_W-1:0]     free_rd;
    logic [qm_geometry_pkg::PAGE_W-1:0]     free_wr;
    logic [qm_geometry_pkg::FREE_CNT_W-1:0] free_cnt;
    logic                                   alloc_pop;

    logic                                   busy;
    logic [qm_queue_pkg::QUEUE_W-1:0]       q_hold;
    logic [qm_geometry_pkg::BYTES_W-1:0]    bytes_hold;
    logic                                   need_page;
    logic                                   no_page;

    //////////////////////////////
    // Free page list

    // Pages 0 to 7 in order after reset, released pages go to the back
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (rst) begin
            for (int i = 0; i < qm_geometry_pkg::NUM_PAGES; i++) begin
                free_list[i] <= qm_geometry_pkg::PAGE_W'(i);
            end
            free_rd  <= '0;
            free_wr  <= '0;
            free_cnt <= qm_geometry_pkg::FREE_CNT_W'(qm_geometry_pkg::NUM_PAGES);
        end else begin
            if (release_valid) begin
                free_list[free_wr] <= release_page;
                free_wr            <= free_wr + 1'b1;
            end
            if (alloc_pop) begin
                free_rd <= free_rd + 1'b1;
            end
            free_cnt <= free_cnt + qm_geometry_pkg::FREE_CNT_W'(release_valid)
                                 - qm_geometry_pkg::FREE_CNT_W'(alloc_pop);
        end
    end

    //////////////////////////////
    // Tail update sequencer

    // Lookup cycle when idle, response cycle when busy
    assign enq_ready   = !busy;
    assign tail.rd_req = enq_valid && !busy;
    assign tail.queue  = busy ? q_hold : enq_queue;

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= tail.rd_req;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail.rd_req) begin
            q_hold     <= enq_queue;
            bytes_hold <= enq_bytes;
        end
    end

    // New page when the queue owns none or its last page is full
    assign need_page = !tail.page_valid || (tail.tail_ptr == '0);

    // Count before this cycle's release decides
    assign no_page = need_page && (free_cnt == '0);

    assign tail.wr_en     = tail.rd_valid && !no_page;
    assign enq_drop       = tail.rd_valid && no_page;
    assign tail.alloc     = need_page;
    assign tail.new_page  = free_list[free_rd];
    assign tail.new_tail  = tail.tail_ptr + 1'b1;
    assign tail.add_bytes = bytes_hold;

    assign alloc_pop = tail.wr_en && tail.alloc;

endmodule

//--- qm_geometry_pkg.sv
// Page and word geometry of the shared packet buffer
// Widths derived from the geometry
package qm_geometry_pkg;

    // Buffer layout
    localparam int NUM_PAGES      = 8;
    localparam int WORDS_PER_PAGE = 4;
    localparam int BYTES_PER_WORD = 8;

    // Page pointer into the buffer
    localparam int PAGE_W = $clog2(NUM_PAGES);

    // Word offset inside one page
    localparam int OFFSET_W = $clog2(WORDS_PER_PAGE);

    // Buffer word address is page then offset
    localparam int ADDR_W = PAGE_W + OFFSET_W;

    // Byte count of a single word, 0 to BYTES_PER_WORD
    localparam int BYTES_W = $clog2(BYTES_PER_WORD) + 1;

    // Free page count, 0 to NUM_PAGES
    localparam int FREE_CNT_W = $clog2(NUM_PAGES + 1);

endpackage

//--- qm_ifs.sv
// Tail and head lookup ports between the engines and the queue state store
`timescale 1ns/1ps

interface tail_port_if;

    // Producer side
    logic                                 rd_req;
    logic [qm_queue_pkg::QUEUE_W-1:0]     queue;
    logic                                 wr_en;
    logic [qm_geometry_pkg::OFFSET_W-1:0] new_tail;
    logic                                 alloc;
    logic [qm_geometry_pkg::PAGE_W-1:0]   new_page;
    logic [qm_geometry_pkg::BYTES_W-1:0]  add_bytes;

    // Store side, registered lookup result
    logic                                 rd_valid;
    logic [qm_geometry_pkg::OFFSET_W-1:0] tail_ptr;
    logic [qm_geometry_pkg::PAGE_W-1:0]   page_ptr;
    logic                                 page_valid;

    modport producer (
        output rd_req, queue, wr_en, new_tail, alloc, new_page, add_bytes,
        input  rd_valid, tail_ptr, page_ptr, page_valid
    );

    modport store (
        input  rd_req, queue, wr_en, new_tail, alloc, new_page, add_bytes,
        output rd_valid, tail_ptr, page_ptr, page_valid
    );

endinterface

interface head_port_if;

    logic                                 req;
    logic [qm_queue_pkg::QUEUE_W-1:0]     queue;
    logic [qm_geometry_pkg::BYTES_W-1:0]  sub_bytes;

    logic                                 rd_valid;
    logic [qm_geometry_pkg::OFFSET_W-1:0] head_ptr;
    logic [qm_geometry_pkg::PAGE_W-1:0]   page_ptr;

    modport consumer (
        output req, queue, sub_bytes,
        input  rd_valid, head_ptr, page_ptr
    );

    modport store (
        input  req, queue, sub_bytes,
        output rd_valid, head_ptr, page_ptr
    );

endinterface

//--- qm_queue_pkg.sv
// Queue count and per-queue counter widths
package qm_queue_pkg;

    localparam int NUM_QUEUES = 4;
    localparam int QUEUE_W    = $clog2(NUM_QUEUES);

    // Byte occupancy up to the whole buffer, 256 bytes
    localparam int OCC_W = $clog2(qm_geometry_pkg::NUM_PAGES * qm_geometry_pkg::WORDS_PER_PAGE *
                                  qm_geometry_pkg::BYTES_PER_WORD + 1);

    // Word count up to the whole buffer, 32 words
    localparam int WCNT_W = $clog2(qm_geometry_pkg::NUM_PAGES *
                                   qm_geometry_pkg::WORDS_PER_PAGE + 1);

    // Page pointer FIFO kept for each queue
    localparam int PF_DEPTH = 4;
    localparam int PF_IDX_W = $clog2(PF_DEPTH);

endpackage

//--- qm_queue_states.sv
// Per-queue tail and head offsets, page pointer FIFOs, word counts and occupancies
// Registered tail and head lookups, occupancy read port and empty flags
`timescale 1ns/1ps

module qm_queue_states (
    input  logic                                enqueue_queue_occupancy_a4l,
    input  logic                                rst,
    tail_port_if.store                          tail,
    head_port_if.store                          head,
    input  logic                                occ_rd_en,
    input  logic [qm_queue_pkg::QUEUE_W-1:0]    occ_rd_queue,
    output logic                                occ_rd_valid,
    output logic [qm_queue_pkg::OCC_W-1:0]      occ_rd_data,
    output logic [qm_queue_pkg::NUM_QUEUES-1:0] queue_empty
);

    logic [qm_geometry_pkg::OFFSET_W-1:0] tail_off [qm_queue_pkg::NUM_QUEUES];
    logic [qm_geometry_pkg::OFFSET_W-1:0] head_off [qm_queue_pkg::NUM_QUEUES];

    // Page pointer FIFO, one per queue
    logic [qm_geometry_pkg::PAGE_W-1:0]
        pf_mem [qm_queue_pkg::NUM_QUEUES][qm_queue_pkg::PF_DEPTH];
    logic [qm_queue_pkg::PF_IDX_W-1:0]    pf_rd [qm_queue_pkg::NUM_QUEUES];
    logic [qm_queue_pkg::PF_IDX_W-1:0]    pf_wr [qm_queue_pkg::NUM_QUEUES];
    logic [qm_queue_pkg::PF_IDX_W:0]      pf_cnt [qm_queue_pkg::NUM_QUEUES];

    logic [qm_queue_pkg::WCNT_W-1:0]      wcnt [qm_queue_pkg::NUM_QUEUES];
    logic [qm_queue_pkg::OCC_W-1:0]       occ [qm_queue_pkg::NUM_QUEUES];

    // Per-queue strobes decoded from both ports
    logic [qm_queue_pkg::NUM_QUEUES-1:0]  wr_hit;
    logic [qm_queue_pkg::NUM_QUEUES-1:0]  push;
    logic [qm_queue_pkg::NUM_QUEUES-1:0]  hd_hit;
    logic [qm_queue_pkg::NUM_QUEUES-1:0]  pop;
    logic [qm_queue_pkg::NUM_QUEUES-1:0]  rsp_hit;

    always_comb begin
        for (int i = 0; i < qm_queue_pkg::NUM_QUEUES; i++) begin
            wr_hit[i]  = tail.wr_en && (tail.queue == qm_queue_pkg::QUEUE_W'(i));
            push[i]    = wr_hit[i] && tail.alloc;
            hd_hit[i]  = head.req && (head.queue == qm_queue_pkg::QUEUE_W'(i));
            // Last word of the head page frees that page
            pop[i]     = hd_hit[i] && (head_off[i] == qm_geometry_pkg::WORDS_PER_PAGE - 1);
            // Response cycle carries the byte count to subtract
            rsp_hit[i] = head.rd_valid && (head.queue == qm_queue_pkg::QUEUE_W'(i));
            queue_empty[i] = (wcnt[i] == '0);
        end
    end

    //////////////////////////////
    // Pointer and counter state

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (rst) begin
            tail_off <= '{default: '0};
            head_off <= '{default: '0};
            pf_rd    <= '{default: '0};
            pf_wr    <= '{default: '0};
            pf_cnt   <= '{default: '0};
            wcnt     <= '{default: '0};
            occ      <= '{default: '0};
        end else begin
            for (int i = 0; i < qm_queue_pkg::NUM_QUEUES; i++) begin
                if (wr_hit[i]) begin
                    tail_off[i] <= tail.new_tail;
                end
                if (push[i]) begin
                    pf_wr[i] <= pf_wr[i] + 1'b1;
                end
                if (hd_hit[i]) begin
                    head_off[i] <= head_off[i] + 1'b1;
                end
                if (pop[i]) begin
                    pf_rd[i] <= pf_rd[i] + 1'b1;
                end
                pf_cnt[i] <= pf_cnt[i] + (qm_queue_pkg::PF_IDX_W + 1)'(push[i])
                                       - (qm_queue_pkg::PF_IDX_W + 1)'(pop[i]);
                // Enqueue and dequeue on one queue merge into a single update
                wcnt[i] <= wcnt[i] + qm_queue_pkg::WCNT_W'(wr_hit[i])
                                   - qm_queue_pkg::WCNT_W'(rsp_hit[i]);
                occ[i]  <= occ[i]
                         + (wr_hit[i]  ? qm_queue_pkg::OCC_W'(tail.add_bytes) : '0)
                         - (rsp_hit[i] ? qm_queue_pkg::OCC_W'(head.sub_bytes) : '0);
            end
        end
    end

    // Page pointer storage
    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail.wr_en && tail.alloc) begin
            pf_mem[tail.queue][pf_wr[tail.queue]] <= tail.new_page;
        end
    end

    //////////////////////////////
    // Lookups and occupancy read

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (rst) begin
            tail.rd_valid <= 1'b0;
            head.rd_valid <= 1'b0;
            occ_rd_valid  <= 1'b0;
        end else begin
            tail.rd_valid <= tail.rd_req;
            head.rd_valid <= head.req;
            occ_rd_valid  <= occ_rd_en;
        end
    end

    always_ff @(posedge enqueue_queue_occupancy_a4l) begin
        if (tail.rd_req) begin
            tail.tail_ptr   <= tail_off[tail.queue];
            // Tail page is the newest FIFO entry
            tail.page_ptr   <= pf_mem[tail.queue][pf_wr[tail.queue] - 1'b1];
            tail.page_valid <= (pf_cnt[tail.queue] != '0);
        end
        if (head.req) begin
            head.head_ptr <= head_off[head.queue];
            head.page_ptr <= pf_mem[head.queue][pf_rd[head.queue]];
        end
        if (occ_rd_en) begin
            occ_rd_data <= occ[occ_rd_queue];
        end
    end

endmodule

//--- qm_top.sv
// Queue manager top level
`timescale 1ns/1ps

module qm_top (
    input  logic                                enqueue_queue_occupancy_a4l,
    input  logic                                rst,
    input  logic                                enq_valid,
    input  logic [qm_queue_pkg::QUEUE_W-1:0]    enq_queue,
    input  logic [qm_geometry_pkg::BYTES_W-1:0] enq_bytes,
    output logic                                enq_ready,
    output logic                                enq_drop,
    input  logic                                deq_valid,
    input  logic [qm_queue_pkg::QUEUE_W-1:0]    deq_queue,
    input  logic [qm_geometry_pkg::BYTES_W-1:0] deq_bytes,
    output logic                                deq_ready,
    output logic                                rd_valid,
    output logic [qm_geometry_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                                occ_rd_en,
    input  logic [qm_queue_pkg::QUEUE_W-1:0]    occ_rd_queue,
    output logic                                occ_rd_valid,
    output logic [qm_queue_pkg::OCC_W-1:0]      occ_rd_data,
    output logic [qm_queue_pkg::NUM_QUEUES-1:0] queue_empty
);

    logic                               release_valid;
    logic [qm_geometry_pkg::PAGE_W-1:0] release_page;

    tail_port_if tail_bus ();
    head_port_if head_bus ();

    qm_enqueue u_enqueue (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .rst           (rst),
        .enq_valid     (enq_valid),
        .enq_queue     (enq_queue),
        .enq_bytes     (enq_bytes),
        .enq_ready     (enq_ready),
        .enq_drop      (enq_drop),
        .release_valid (release_valid),
        .release_page  (release_page),
        .tail          (tail_bus.producer)
    );

    qm_queue_states u_queue_states (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .rst          (rst),
        .tail         (tail_bus.store),
        .head         (head_bus.store),
        .occ_rd_en    (occ_rd_en),
        .occ_rd_queue (occ_rd_queue),
        .occ_rd_valid (occ_rd_valid),
        .occ_rd_data  (occ_rd_data),
        .queue_empty  (queue_empty)
    );

    qm_dequeue u_dequeue (
        .enqueue_queue_occupancy_a4l (enqueue_queue_occupancy_a4l),
        .rst           (rst),
        .deq_valid     (deq_valid),
        .deq_queue     (deq_queue),
        .deq_bytes     (deq_bytes),
        .deq_ready     (deq_ready),
        .queue_empty   (queue_empty),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .release_valid (release_valid),
        .release_page  (release_page),
        .head          (head_bus.consumer)
    );

endmodule

//--- tb_qm.sv
// Queue manager testbench with reference model, compare process and timeout
`timescale 1ns/1ps

module tb_qm;

    // Directed phases plus 400 random slots and drains, two cycles per slot
    localparam int STIM_SLOTS  = 660;
    localparam int STIM_CYCLES = 8 + 2 * STIM_SLOTS;
    localparam int CYCLE_LIMIT = 3 * STIM_CYCLES;

    logic       enqueue_queue_occupancy_a4l;
    logic       rst;
    logic       enq_valid, deq_valid, occ_rd_en;
    logic [1:0] enq_queue, deq_queue, occ_rd_queue;
    logic [3:0] enq_bytes, deq_bytes;
    logic       enq_ready, enq_drop, deq_ready, rd_valid, occ_rd_valid;
    logic [4:0] rd_addr;
    logic [8:0] occ_rd_data;
    logic [3:0] queue_empty;

    // Model state
    int fl [8];
    int fl_rd, fl_wr, fl_cnt;
    int waddr [4][32];
    int wbytes [4][32];
    int w_rd [4], w_wr [4], w_cnt [4];
    int tail_off [4], owned [4], cur_page [4], occ_m [4];
    int exp_addr [$];
    int exp_occ [$];
    int exp_drops;
    int seed;
    int cycles;

    qm_top DUT (.*);

    initial begin
        enqueue_queue_occupancy_a4l = 1'b0;
        forever #4 enqueue_queue_occupancy_a4l = ~enqueue_queue_occupancy_a4l;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Fail at %0t: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    // Reference model for one stimulus slot
    // Dequeue sees the state before the enqueue
    // Allocation sees the free list before this slot's release
    function automatic void model_slot(input bit de, input int eq, input int eb,
                                       input bit dd, input int dq, input int db,
                                       input bit dr, input int oq);
        int  addr;
        bit  need;
        bit  rel;
        int  rel_page;
        rel      = 1'b0;
        rel_page = 0;
        if (dr) begin
            exp_occ.push_back(occ_m[oq]);
        end
        if (dd && w_cnt[dq] > 0) begin
            addr = waddr[dq][w_rd[dq]];
            exp_addr.push_back(addr);
            w_rd[dq]   = (w_rd[dq] + 1) % 32;
            w_cnt[dq] -= 1;
            occ_m[dq] -= db;
            if (addr % 4 == 3) begin
                rel      = 1'b1;
                rel_page = addr / 4;
            end
        end
        if (de) begin
            need = (owned[eq] == 0) || (tail_off[eq] == 0);
            if (need && fl_cnt == 0) begin
                exp_drops += 1;
            end else begin
                if (need) begin
                    cur_page[eq] = fl[fl_rd];
                    fl_rd        = (fl_rd + 1) % 8;
                    fl_cnt      -= 1;
                    owned[eq]   += 1;
                end
                waddr[eq][w_wr[eq]]  = cur_page[eq] * 4 + tail_off[eq];
                wbytes[eq][w_wr[eq]] = eb;
                w_wr[eq]     = (w_wr[eq] + 1) % 32;
                w_cnt[eq]   += 1;
                occ_m[eq]   += eb;
                tail_off[eq] = (tail_off[eq] + 1) % 4;
            end
        end
        if (rel) begin
            fl[fl_wr] = rel_page;
            fl_wr     = (fl_wr + 1) % 8;
            fl_cnt   += 1;
            owned[dq] -= 1;
        end
    endfunction

    function automatic int front_bytes(input int q);
        return (w_cnt[q] > 0) ? wbytes[q][w_rd[q]] : 5;
    endfunction

    task automatic run_slot(input bit de, input int eq, input int eb, input bit dd,
                            input int dq, input int db, input bit dr, input int oq);
        @(posedge enqueue_queue_occupancy_a4l);
        model_slot(de, eq, eb, dd, dq, db, dr, oq);
        enq_valid    <= de;
        enq_queue    <= eq[1:0];
        enq_bytes    <= eb[3:0];
        deq_valid    <= dd;
        deq_queue    <= dq[1:0];
        deq_bytes    <= db[3:0];
        occ_rd_en    <= dr;
        occ_rd_queue <= oq[1:0];
        @(negedge enqueue_queue_occupancy_a4l);
        check_value("enq_ready", enq_ready, 1);
        check_value("deq_ready", deq_ready, 1);
        @(posedge enqueue_queue_occupancy_a4l);
        enq_valid <= 1'b0;
        deq_valid <= 1'b0;
        occ_rd_en <= 1'b0;
    endtask

    task automatic drain_all();
        for (int q = 0; q < 4; q++) begin
            while (w_cnt[q] > 0) begin
                run_slot(0, 0, 0, 1, q, front_bytes(q), 1, q);
            end
        end
        run_slot(0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    // Compare process for every pulse output
    initial begin
        forever begin
            @(negedge enqueue_queue_occupancy_a4l);
            if (!rst) begin
                if (rd_valid) begin
                    if (exp_addr.size() == 0) report_failure("unexpected rd_valid pulse");
                    else check_value("rd_addr", rd_addr, exp_addr.pop_front());
                end
                if (enq_drop) begin
                    if (exp_drops == 0) report_failure("unexpected enq_drop pulse");
                    else exp_drops -= 1;
                end
                if (occ_rd_valid) begin
                    if (exp_occ.size() == 0) report_failure("unexpected occ_rd_valid pulse");
                    else check_value("occ_rd_data", occ_rd_data, exp_occ.pop_front());
                end
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge enqueue_queue_occupancy_a4l);
            cycles += 1;
            if (cycles > CYCLE_LIMIT) report_failure("timeout, run did not finish");
        end
    end

    initial begin
        int r;
        bit de, dd, dr;
        int eq, dq, oq;
        seed = 53949;
        rst = 1'b1;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_bytes = '0;
        deq_valid = 1'b0;
        deq_queue = '0;
        deq_bytes = '0;
        occ_rd_en = 1'b0;
        occ_rd_queue = '0;
        for (int i = 0; i < 8; i++) fl[i] = i;
        fl_rd = 0;
        fl_wr = 0;
        fl_cnt = 8;
        exp_drops = 0;
        for (int q = 0; q < 4; q++) begin
            w_rd[q]     = 0;
            w_wr[q]     = 0;
            w_cnt[q]    = 0;
            tail_off[q] = 0;
            owned[q]    = 0;
            cur_page[q] = 0;
            occ_m[q]    = 0;
        end
        repeat (8) @(posedge enqueue_queue_occupancy_a4l);
        rst <= 1'b0;

        //////////////////////////////
        // Reset state and FIFO order
        @(negedge enqueue_queue_occupancy_a4l);
        check_value("queue_empty", queue_empty, 4'hf);
        repeat (3) run_slot(0, 0, 0, 0, 0, 0, 0, 0);
        for (int i = 0; i < 15; i++) run_slot(1, i % 3, 1 + i % 8, 0, 0, 0, 0, 0);
        for (int i = 0; i < 15; i++) run_slot(0, 0, 0, 1, i % 3, front_bytes(i % 3), 1, i % 3);

        // Enqueue and dequeue on one queue together
        for (int i = 0; i < 4; i++) run_slot(1, 1, 2 + i, 0, 0, 0, 1, 1);
        for (int i = 0; i < 6; i++) run_slot(1, 1, 1 + i, 1, 1, front_bytes(1), 1, 1);
        drain_all();

        //////////////////////////////
        // Full buffer, drop, then release
        for (int i = 0; i < 32; i++) run_slot(1, i % 4, 8, 0, 0, 0, 0, 0);
        run_slot(1, 0, 3, 0, 0, 0, 1, 0);
        run_slot(0, 0, 0, 0, 0, 0, 1, 0);
        for (int i = 0; i < 4; i++) run_slot(0, 0, 0, 1, 1, front_bytes(1), 0, 0);
        run_slot(1, 0, 6, 0, 0, 0, 1, 0);
        run_slot(0, 0, 0, 0, 0, 0, 1, 0);
        drain_all();

        // Empty queue dequeue
        run_slot(0, 0, 0, 1, 2, 7, 1, 2);
        run_slot(0, 0, 0, 0, 0, 0, 1, 2);
        @(negedge enqueue_queue_occupancy_a4l);
        check_value("queue_empty", queue_empty, 4'hf);

        //////////////////////////////
        // Random mix
        for (int i = 0; i < 400; i++) begin
            r  = $random(seed);
            de = r[0];
            dd = r[1];
            dr = r[2];
            eq = r[5:4];
            dq = r[7:6];
            oq = r[9:8];
            if (owned[eq] >= 4 && tail_off[eq] == 0) de = 1'b0;
            run_slot(de, eq, 1 + r[12:10], dd, dq, front_bytes(dq), dr, oq);
        end
        drain_all();
        repeat (2) run_slot(0, 0, 0, 0, 0, 0, 0, 0);

        if (exp_addr.size() != 0 || exp_occ.size() != 0 || exp_drops != 0) begin
            report_failure("expected pulses never arrived");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- verilog.f
qm_geometry_pkg.sv
qm_queue_pkg.sv
qm_ifs.sv
qm_enqueue.sv
qm_queue_states.sv
qm_dequeue.sv
qm_top.sv
qm_checker.sv
tb_qm.sv
